//--- Bender.yml
package:
  name: mips_core

sources:
  - verilog/mips_isa_pkg.sv
  - verilog/mips_core_pkg.sv
  - verilog/mips_fetch.sv
  - verilog/mips_decode.sv
  - verilog/mips_regfile.sv
  - verilog/mips_alu.sv
  - verilog/mips_core.sv
  - target: test
    files:
      - tests/mips_core_checker.sv
      - tests/mips_core_asserts.sv
      - tests/mips_core_tb.sv

//--- mips_core.f
verilog/mips_isa_pkg.sv
verilog/mips_core_pkg.sv
verilog/mips_fetch.sv
verilog/mips_decode.sv
verilog/mips_regfile.sv
verilog/mips_alu.sv
verilog/mips_core.sv
tests/mips_core_checker.sv
tests/mips_core_asserts.sv
tests/mips_core_tb.sv

//--- tests/mips_core_asserts.sv
// port-level properties of mips_core, bound into every instance; counts its own failures
`default_nettype none

module mips_core_asserts (
   input wire logic        clk,
   input wire logic        rst_b,
   input wire logic [29:0] inst_addr,
   input wire logic [3:0]  mem_write_en,
   input wire logic        halted
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;

   // word stores only, so the mask is all lanes or none
   a_mask_full: assert property (@(posedge clk) disable iff (!rst_b)
      (mem_write_en == 4'h0) || (mem_write_en == 4'hf))
   else
   begin
      $error("partial store mask %h", mem_write_en);
      fail_count++;
   end

   // halt is sticky and the pc freezes on the halting instruction
   a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> (halted && $stable(inst_addr)))
   else
   begin
      $error("halted dropped or inst_addr moved while halted");
      fail_count++;
   end

   // nothing halted and nothing stored while reset is held
   a_reset_quiet: assert property (@(posedge clk)
      !rst_b |-> (!halted && (mem_write_en == 4'h0)))
   else
   begin
      $error("core not quiet during reset");
      fail_count++;
   end

endmodule

bind mips_core mips_core_asserts u_asserts (
   .clk          (clk),
   .rst_b        (rst_b),
   .inst_addr    (inst_addr),
   .mem_write_en (mem_write_en),
   .halted       (halted)
);

`default_nettype wire

//--- tests/mips_core_checker.sv
// samples the data port at the falling edge; expectations must be queued in program order
`default_nettype none

module mips_core_checker (
   input wire logic                clk,
   input wire logic                rst_b,
   input wire logic [29:0]         inst_addr,
   input wire logic [29:0]         mem_addr,
   input mips_isa_pkg::word_t      mem_wdata,
   input wire logic [3:0]          mem_write_en,
   input wire logic                halted
);
   timeunit 1ns;
   timeprecision 100ps;

   // one expected store: the instruction that made the value, its operands, the slot
   typedef struct packed {
      mips_isa_pkg::instr_t iw;
      mips_isa_pkg::word_t  a;
      mips_isa_pkg::word_t  b;
      logic [29:0]          addr;
   } exp_t;

   exp_t pending[$];
   int   errors = 0;
   int   checked = 0;

   // value the instruction should produce from rs value a and rt value b
   function automatic mips_isa_pkg::word_t ref_result(mips_isa_pkg::instr_t iw,
                                                      mips_isa_pkg::word_t a,
                                                      mips_isa_pkg::word_t b);
      logic [15:0]         imm;
      mips_isa_pkg::word_t sx;
      mips_isa_pkg::word_t zx;
      mips_isa_pkg::word_t fill;
      imm  = {iw.rd, iw.shamt, iw.funct};
      sx   = {{16{imm[15]}}, imm};
      zx   = {16'h0000, imm};
      // sign bits that an arithmetic right shift brings in
      fill = b[31] ? ~(32'hffff_ffff >> iw.shamt) : 32'h0;
      if (iw.op == mips_isa_pkg::OP_SPECIAL)
      begin
         case (iw.funct)
            mips_isa_pkg::F_ADDU: return a + b;
            mips_isa_pkg::F_SUBU: return a - b;
            mips_isa_pkg::F_AND:  return a & b;
            mips_isa_pkg::F_OR:   return a | b;
            mips_isa_pkg::F_XOR:  return a ^ b;
            mips_isa_pkg::F_NOR:  return ~(a | b);
            // differing signs decide on their own
            mips_isa_pkg::F_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            mips_isa_pkg::F_SLL:  return b << iw.shamt;
            mips_isa_pkg::F_SRL:  return b >> iw.shamt;
            mips_isa_pkg::F_SRA:  return (b >> iw.shamt) | fill;
            default:              return 32'hxxxx_xxxx;
         endcase
      end
      case (iw.op)
         mips_isa_pkg::OP_ADDIU: return a + sx;
         mips_isa_pkg::OP_SLTI:  return (a[31] != sx[31]) ? {31'd0, a[31]} : {31'd0, a < sx};
         mips_isa_pkg::OP_ANDI:  return a & zx;
         mips_isa_pkg::OP_ORI:   return a | zx;
         mips_isa_pkg::OP_XORI:  return a ^ zx;
         mips_isa_pkg::OP_LUI:   return {imm, 16'h0000};
         default:                return 32'hxxxx_xxxx;
      endcase
   endfunction

   task automatic expect_store(mips_isa_pkg::instr_t iw, mips_isa_pkg::word_t a,
                               mips_isa_pkg::word_t b, logic [29:0] addr);
      pending.push_back('{iw: iw, a: a, b: b, addr: addr});
   endtask

   task automatic check_reset(logic [29:0] start_word);
      if (inst_addr !== start_word || halted !== 1'b0 || mem_write_en !== 4'h0)
      begin
         $display("Fail at %0t ns: after reset inst_addr %h halted %b mask %h",
                  $time, inst_addr, halted, mem_write_en);
         errors++;
      end
   endtask

   task automatic check_halt(logic [29:0] halt_word);
      if (halted !== 1'b1 || inst_addr !== halt_word)
      begin
         $display("Fail at %0t ns: halted %b inst_addr %h, expected held at %h",
                  $time, halted, inst_addr, halt_word);
         errors++;
      end
   endtask

   // anything still queued at the end of a run never reached memory
   task automatic flush_pending(output int missing);
      missing = pending.size();
      if (missing > 0)
      begin
         $display("%0d expected stores never happened", missing);
         errors += missing;
         pending.delete();
      end
   endtask

   always @(negedge clk)
   begin
      exp_t                e;
      mips_isa_pkg::word_t want;
      if (rst_b && mem_write_en != 4'h0)
      begin
         if (pending.size() == 0)
         begin
            $display("unexpected store of %h to word %h at %0t ns", mem_wdata, mem_addr, $time);
            errors++;
         end
         else
         begin
            e    = pending.pop_front();
            want = ref_result(e.iw, e.a, e.b);
            checked++;
            if (mem_addr !== e.addr || mem_wdata !== want)
            begin
               $display("Fail at %0t ns: store word %h data %h, expected word %h data %h",
                        $time, mem_addr, mem_wdata, e.addr, want);
               errors++;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- tests/mips_core_tb.sv
// each test is its own program ending in a halt; data slots live at byte address 4*slot
`default_nettype none

module mips_core_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam mips_isa_pkg::word_t TEXT_START   = 32'h0040_0000;
   localparam logic [29:0]         TEXT_WORD    = TEXT_START[31:2];
   localparam int                  HALT_TIMEOUT = 500;
   localparam logic [15:0]         MARKER_OFS   = 16'd252;

   logic                 clk;
   logic                 rst_b;
   logic [29:0]          inst_addr;
   mips_isa_pkg::instr_t inst;
   logic [29:0]          mem_addr;
   mips_isa_pkg::word_t  mem_wdata;
   mips_isa_pkg::word_t  mem_rdata;
   logic [3:0]           mem_write_en;
   logic                 halted;
   logic [29:0]          iofs;

   mips_isa_pkg::word_t imem [0:255];
   mips_isa_pkg::word_t dmem [0:63];
   logic [31:0]         lfsr_state;
   int                  wp;
   int                  slot;
   int                  tests_run;
   int                  tests_failed;
   logic                hung;

   mips_core #(
      .TEXT_START (TEXT_START)
   ) u_dut (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .mem_addr     (mem_addr),
      .mem_wdata    (mem_wdata),
      .mem_rdata    (mem_rdata),
      .mem_write_en (mem_write_en),
      .halted       (halted)
   );

   mips_core_checker u_chk (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .mem_addr     (mem_addr),
      .mem_wdata    (mem_wdata),
      .mem_write_en (mem_write_en),
      .halted       (halted)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // both memories answer in the same cycle; outside the program is a reserved opcode
   assign iofs      = inst_addr - TEXT_WORD;
   assign inst      = (iofs < 30'd256) ? mips_isa_pkg::instr_t'(imem[iofs[7:0]])
                    : mips_isa_pkg::instr_t'({6'h3f, inst_addr[25:0] ^ {22'd0, inst_addr[29:26]}});
   assign mem_rdata = (mem_addr < 30'd64) ? dmem[mem_addr[5:0]] : {2'b10, mem_addr};

   always @(posedge clk)
   begin
      for (int l = 0; l < 4; l++)
         if (mem_write_en[l] && mem_addr < 30'd64)
            dmem[mem_addr[5:0]][8*l +: 8] <= mem_wdata[8*l +: 8];
   end

   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // take n bits msb first with one lfsr step per bit
   function automatic mips_isa_pkg::word_t take_bits(int n);
      mips_isa_pkg::word_t v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic mips_isa_pkg::word_t enc_r(logic [5:0] funct, logic [4:0] rs,
                                                 logic [4:0] rt, logic [4:0] rd, logic [4:0] sh);
      return {6'h00, rs, rt, rd, sh, funct};
   endfunction

   function automatic mips_isa_pkg::word_t enc_i(logic [5:0] op, logic [4:0] rs,
                                                 logic [4:0] rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // target given as an instruction index in imem
   function automatic mips_isa_pkg::word_t enc_j(logic [5:0] op, int idx);
      logic [29:0] w;
      w = TEXT_WORD + 30'(idx);
      return {op, w[25:0]};
   endfunction

   function automatic logic [5:0] pick_rr_funct(int k);
      case (k)
         0:       return mips_isa_pkg::F_ADDU;
         1:       return mips_isa_pkg::F_SUBU;
         2:       return mips_isa_pkg::F_AND;
         3:       return mips_isa_pkg::F_OR;
         4:       return mips_isa_pkg::F_XOR;
         5:       return mips_isa_pkg::F_NOR;
         default: return mips_isa_pkg::F_SLT;
      endcase
   endfunction

   function automatic logic [5:0] pick_imm_op(int k);
      case (k)
         0:       return mips_isa_pkg::OP_ADDIU;
         1:       return mips_isa_pkg::OP_SLTI;
         2:       return mips_isa_pkg::OP_ANDI;
         3:       return mips_isa_pkg::OP_ORI;
         4:       return mips_isa_pkg::OP_XORI;
         default: return mips_isa_pkg::OP_LUI;
      endcase
   endfunction

   task automatic emit(mips_isa_pkg::word_t w);
      imem[wp] = w;
      wp++;
   endtask

   task automatic clear_program();
      for (int i = 0; i < 256; i++)
         imem[i] = {6'h3f, 26'(i)};
      wp   = 0;
      slot = 0;
   endtask

   task automatic load_const(logic [4:0] r, mips_isa_pkg::word_t v);
      emit(enc_i(mips_isa_pkg::OP_LUI, 5'd0, r, v[31:16]));
      emit(enc_i(mips_isa_pkg::OP_ORI, r, r, v[15:0]));
   endtask

   // queue the expectation, then store register r to the next slot
   task automatic store_checked(logic [4:0] r, mips_isa_pkg::word_t iw,
                                mips_isa_pkg::word_t a, mips_isa_pkg::word_t b);
      u_chk.expect_store(mips_isa_pkg::instr_t'(iw), a, b, 30'(slot));
      emit(enc_i(mips_isa_pkg::OP_SW, 5'd0, r, 16'(4 * slot)));
      slot++;
   endtask

   // a plain value is expected as v + 0
   task automatic store_value(logic [4:0] r, mips_isa_pkg::word_t v);
      store_checked(r, enc_r(mips_isa_pkg::F_ADDU, 5'd1, 5'd2, 5'd3, 5'd0), v, 32'h0);
   endtask

   // must never execute since the checker has nothing queued for it
   task automatic store_marker();
      emit(enc_i(mips_isa_pkg::OP_SW, 5'd0, 5'd5, MARKER_OFS));
   endtask

   task automatic run_program(string name, int halt_idx);
      int errs0;
      int asrt0;
      int checks0;
      int cyc;
      int missing;
      logic ok;
      if (hung)
         return;
      errs0   = u_chk.errors;
      asrt0   = u_dut.u_asserts.fail_count;
      checks0 = u_chk.checked;
      @(posedge clk);
      #2 rst_b = 1'b0;
      repeat (2) @(posedge clk);
      #2 rst_b = 1'b1;
      @(negedge clk);
      u_chk.check_reset(TEXT_WORD);
      cyc = 0;
      while (!halted && cyc < HALT_TIMEOUT)
      begin
         @(negedge clk);
         cyc++;
      end
      if (!halted)
      begin
         $display("timeout: test %s did not halt within %0d cycles", name, HALT_TIMEOUT);
         hung = 1'b1;
      end
      else
      begin
         // a few idle cycles to catch late stores or a moving pc
         repeat (4) @(negedge clk);
         u_chk.check_halt(TEXT_WORD + 30'(halt_idx));
         u_chk.flush_pending(missing);
         ok = (u_chk.errors == errs0) && (u_dut.u_asserts.fail_count == asrt0);
         tests_run++;
         if (!ok)
            tests_failed++;
         $display("test %s %s, %0d stores checked", name, ok ? "ok" : "failed",
                  u_chk.checked - checks0);
      end
   endtask

   initial
   begin
      mips_isa_pkg::word_t a;
      mips_isa_pkg::word_t b;
      mips_isa_pkg::word_t iw;
      mips_isa_pkg::word_t r;
      int                  h;
      int                  k;
      rst_b        = 1'b0;
      hung         = 1'b0;
      lfsr_state   = 32'h277d6db1;
      tests_run    = 0;
      tests_failed = 0;
      for (int i = 0; i < 64; i++)
         dmem[i] = 32'hd0d0_0000 ^ (i * 32'h0001_0101);
      clear_program();

      // random register-register ops
      for (int n = 0; n < 12; n++)
      begin
         a  = take_bits(32);
         b  = take_bits(32);
         k  = int'(take_bits(3)) % 7;
         iw = enc_r(pick_rr_funct(k), 5'd1, 5'd2, 5'd3, 5'd0);
         load_const(5'd1, a);
         load_const(5'd2, b);
         emit(iw);
         store_checked(5'd3, iw, a, b);
      end
      h = wp;
      emit(enc_r(mips_isa_pkg::F_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program("alu_rr", h);

      // shifts by shamt, then every immediate op
      clear_program();
      for (int rep = 0; rep < 2; rep++)
      begin
         for (int s = 0; s < 3; s++)
         begin
            b  = take_bits(32);
            r  = take_bits(5);
            iw = enc_r((s == 0) ? mips_isa_pkg::F_SLL : (s == 1) ? mips_isa_pkg::F_SRL
                       : mips_isa_pkg::F_SRA, 5'd0, 5'd2, 5'd3, r[4:0]);
            load_const(5'd2, b);
            emit(iw);
            store_checked(5'd3, iw, 32'h0, b);
         end
         for (int m = 0; m < 6; m++)
         begin
            a  = take_bits(32);
            r  = take_bits(16);
            iw = enc_i(pick_imm_op(m), 5'd1, 5'd3, r[15:0]);
            load_const(5'd1, a);
            emit(iw);
            store_checked(5'd3, iw, a, 32'h0);
         end
      end
      h = wp;
      emit(enc_r(mips_isa_pkg::F_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program("shift_imm", h);

      // store, load back, add an immediate, store again
      clear_program();
      for (int n = 0; n < 3; n++)
      begin
         a = take_bits(32);
         r = take_bits(16);
         load_const(5'd1, a);
         k = slot;
         store_value(5'd1, a);
         emit(enc_i(mips_isa_pkg::OP_LW, 5'd0, 5'd4, 16'(4 * k)));
         iw = enc_i(mips_isa_pkg::OP_ADDIU, 5'd4, 5'd4, r[15:0]);
         emit(iw);
         store_checked(5'd4, iw, a, 32'h0);
      end
      h = wp;
      emit(enc_r(mips_isa_pkg::F_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program("load", h);

      // branches and jumps with a marker store in each skipped slot
      clear_program();
      a = take_bits(32);
      load_const(5'd1, a);
      load_const(5'd2, a);
      load_const(5'd5, 32'hbad0_0bad);
      emit(enc_i(mips_isa_pkg::OP_BEQ, 5'd1, 5'd2, 16'd1));
      store_marker();
      store_value(5'd1, a);
      // equal operands so bne falls through
      emit(enc_i(mips_isa_pkg::OP_BNE, 5'd1, 5'd2, 16'd1));
      store_value(5'd2, a);
      emit(enc_j(mips_isa_pkg::OP_J, wp + 2));
      store_marker();
      // jal at k calls k+3 and links to k+2 where a jump skips the subroutine
      k = wp;
      emit(enc_j(mips_isa_pkg::OP_JAL, k + 3));
      store_marker();
      emit(enc_j(mips_isa_pkg::OP_J, k + 6));
      store_value(mips_isa_pkg::reg_ra, TEXT_START + 32'(4 * k) + 32'd8);
      emit(enc_r(mips_isa_pkg::F_JR, mips_isa_pkg::reg_ra, 5'd0, 5'd0, 5'd0));
      // only reached if jr falls through
      store_marker();
      store_value(5'd1, a);
      h = wp;
      emit(enc_r(mips_isa_pkg::F_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program("control", h);

      // syscall stops the core before the store behind it
      clear_program();
      a = take_bits(32);
      load_const(5'd1, a);
      load_const(5'd5, 32'hbad0_0bad);
      store_value(5'd1, a);
      h = wp;
      emit(enc_r(mips_isa_pkg::F_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      store_marker();
      run_program("halt_syscall", h);

      // same with a reserved opcode
      clear_program();
      a = take_bits(32);
      load_const(5'd1, a);
      load_const(5'd5, 32'hbad0_0bad);
      store_value(5'd1, a);
      h = wp;
      emit({6'h3e, 26'h0});
      store_marker();
      run_program("halt_reserved", h);

      $display("tests run %0d, failed %0d, stores checked %0d, errors %0d, assertion failures %0d",
               tests_run, tests_failed, u_chk.checked, u_chk.errors,
               u_dut.u_asserts.fail_count);
      if (!hung && tests_failed == 0 && u_chk.errors == 0 && u_dut.u_asserts.fail_count == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/mips_alu.sv
// execute stage and write-back mux; no overflow traps, addu/subu wrap silently
`default_nettype none

module mips_alu (
   input  mips_isa_pkg::instr_t inst,
   input  mips_core_pkg::ctrl_t ctrl,
   input  mips_isa_pkg::word_t  rs_data,
   input  mips_isa_pkg::word_t  rt_data,
   input  mips_isa_pkg::word_t  pc,
   input  mips_isa_pkg::word_t  mem_rdata,
   output mips_isa_pkg::word_t  alu_result,
   output mips_isa_pkg::word_t  wb_data,
   output logic                 branch_taken
);

   logic [15:0]         imm;
   mips_isa_pkg::word_t imm_ext;
   mips_isa_pkg::word_t op_b;

   assign imm = {inst.rd, inst.shamt, inst.funct};

   // sign- or zero-extend per instruction
   assign imm_ext = ctrl.imm_signed ? {{16{imm[15]}}, imm} : {16'h0000, imm};
   assign op_b    = ctrl.imm_src ? imm_ext : rt_data;

   always_comb
   begin
      case (ctrl.alu_op)
         mips_core_pkg::ALU_ADD: alu_result = rs_data + op_b;
         mips_core_pkg::ALU_SUB: alu_result = rs_data - op_b;
         mips_core_pkg::ALU_AND: alu_result = rs_data & op_b;
         mips_core_pkg::ALU_OR:  alu_result = rs_data | op_b;
         mips_core_pkg::ALU_XOR: alu_result = rs_data ^ op_b;
         mips_core_pkg::ALU_NOR: alu_result = ~(rs_data | op_b);
         // signed compare, also slti
         mips_core_pkg::ALU_SLT:
            alu_result = {31'd0, ($signed(rs_data) < $signed(op_b))};
         // shifts take rt and shamt only
         mips_core_pkg::ALU_SLL: alu_result = rt_data << inst.shamt;
         mips_core_pkg::ALU_SRL: alu_result = rt_data >> inst.shamt;
         mips_core_pkg::ALU_SRA: alu_result = $signed(rt_data) >>> inst.shamt;
         mips_core_pkg::ALU_LUI: alu_result = {imm, 16'h0000};
         default:                alu_result = '0;
      endcase
   end

   // beq/bne share one comparator
   assign branch_taken = (ctrl.pc_sel == mips_core_pkg::PC_BRANCH)
                         && ((rs_data == rt_data) ^ ctrl.branch_ne);

   always_comb
   begin
      case (ctrl.wb_sel)
         mips_core_pkg::WB_LOAD: wb_data = mem_rdata;
         // jal link value, as the reference core does
         mips_core_pkg::WB_LINK: wb_data = pc + 32'd8;
         default:                wb_data = alu_result;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/mips_core.sv
// single-cycle core on combinational word-addressed memories; word stores only, no stalls
`default_nettype none

module mips_core #(
   parameter mips_isa_pkg::word_t TEXT_START = 32'h0040_0000
) (
   input  wire logic            clk,
   input  wire logic            rst_b,
   output logic [29:0]          inst_addr,
   input  mips_isa_pkg::instr_t inst,
   output logic [29:0]          mem_addr,
   output mips_isa_pkg::word_t  mem_wdata,
   input  mips_isa_pkg::word_t  mem_rdata,
   output logic [3:0]           mem_write_en,
   output logic                 halted
);

   mips_core_pkg::ctrl_t   ctrl;
   mips_isa_pkg::word_t    pc;
   mips_isa_pkg::word_t    rs_data;
   mips_isa_pkg::word_t    rt_data;
   mips_isa_pkg::word_t    alu_result;
   mips_isa_pkg::word_t    wb_data;
   mips_isa_pkg::reg_idx_t wr_idx;
   logic                   branch_taken;

   mips_fetch #(
      .TEXT_START (TEXT_START)
   ) u_fetch (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst         (inst),
      .ctrl         (ctrl),
      .branch_taken (branch_taken),
      .rs_data      (rs_data),
      .pc           (pc),
      .inst_addr    (inst_addr),
      .halted       (halted)
   );

   mips_decode u_decode (
      .inst (inst),
      .ctrl (ctrl)
   );

   // jal targets $ra, R-type rd, everything else rt
   assign wr_idx = ctrl.link   ? mips_isa_pkg::reg_ra :
                   ctrl.dst_rd ? inst.rd : inst.rt;

   mips_regfile u_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs      (inst.rs),
      .rt      (inst.rt),
      .wr_idx  (wr_idx),
      .wr_data (wb_data),
      .we      (ctrl.reg_we),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   mips_alu u_alu (
      .inst         (inst),
      .ctrl         (ctrl),
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .pc           (pc),
      .mem_rdata    (mem_rdata),
      .alu_result   (alu_result),
      .wb_data      (wb_data),
      .branch_taken (branch_taken)
   );

   // data port, address drops the byte offset
   assign mem_addr     = alu_result[31:2];
   assign mem_wdata    = rt_data;
   // full-word mask only, silenced once halted
   assign mem_write_en = {4{ctrl.mem_we & ~halted}};

endmodule

`default_nettype wire

//--- verilog/mips_core_pkg.sv
// internal control encodings of the core; not architectural, free to change with decode
`default_nettype none

package mips_core_pkg;

   // ALU function
   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_NOR = 4'd5,
      ALU_SLT = 4'd6,
      ALU_SLL = 4'd7,
      ALU_SRL = 4'd8,
      ALU_SRA = 4'd9,
      ALU_LUI = 4'd10
   } alu_op_e;

   // next-pc source
   // PC_BRANCH falls back to pc+4 when the compare fails
   typedef enum logic [1:0] {
      PC_SEQ    = 2'd0,
      PC_BRANCH = 2'd1,
      PC_REG    = 2'd2,
      PC_JUMP   = 2'd3
   } pc_sel_e;

   // register write-back source
   typedef enum logic [1:0] {
      WB_ALU  = 2'd0,
      WB_LOAD = 2'd1,
      WB_LINK = 2'd2
   } wb_sel_e;

   // decoded control for one instruction
   typedef struct packed {
      // GPR write enable
      logic    reg_we;
      // destination is rd, else rt
      logic    dst_rd;
      // destination forced to $ra
      logic    link;
      // second operand is the immediate
      logic    imm_src;
      // sign-extend the immediate, else zero-extend
      logic    imm_signed;
      alu_op_e alu_op;
      pc_sel_e pc_sel;
      // bne: invert the equality test
      logic    branch_ne;
      logic    mem_we;
      wb_sel_e wb_sel;
      // syscall or reserved instruction
      logic    halt_req;
   } ctrl_t;

endpackage

`default_nettype wire

//--- verilog/mips_decode.sv
// purely combinational; anything outside the kept subset decodes as a halt with no side effects
`default_nettype none

module mips_decode (
   input  mips_isa_pkg::instr_t inst,
   output mips_core_pkg::ctrl_t ctrl
);

   always_comb
   begin
      // start from a no-op: no writes, sequential pc
      ctrl            = '0;
      ctrl.alu_op     = mips_core_pkg::ALU_ADD;
      ctrl.pc_sel     = mips_core_pkg::PC_SEQ;
      ctrl.wb_sel     = mips_core_pkg::WB_ALU;

      case (inst.op)
         mips_isa_pkg::OP_SPECIAL:
         begin
            case (inst.funct)
               mips_isa_pkg::F_SLL:
               begin
                  ctrl.reg_we = 1'b1;
                  ctrl.dst_rd = 1'b1;
                  ctrl.alu_op = mips_core_pkg::ALU_SLL;
               end
               mips_isa_pkg::F_SRL:
               begin
                  ctrl.reg_we = 1'b1;
                  ctrl.dst_rd = 1'b1;
                  ctrl.alu_op = mips_core_pkg::ALU_SRL;
               end
               mips_isa_pkg::F_SRA:
               begin
                  ctrl.reg_we = 1'b1;
                  ctrl.dst_rd = 1'b1;
                  ctrl.alu_op = mips_core_pkg::ALU_SRA;
               end
               mips_isa_pkg::F_JR:      ctrl.pc_sel = mips_core_pkg::PC_REG;
               mips_isa_pkg::F_SYSCALL: ctrl.halt_req = 1'b1;
               mips_isa_pkg::F_ADDU:
               begin
                  ctrl.reg_we = 1'b1;
                  ctrl.dst_rd = 1'b1;
               end
               mips_isa_pkg::F_SUBU:
               begin
                  ctrl.reg_we = 1'b1;
                  ctrl.dst_rd = 1'b1;
                  ctrl.alu_op = mips_core_pkg::ALU_SUB;
               end
               mips_isa_pkg::F_AND:
               begin
                  ctrl.reg_we = 1'b1;
                  ctrl.dst_rd = 1'b1;
                  ctrl.alu_op = mips_core_pkg::ALU_AND;
               end
               mips_isa_pkg::F_OR:
               begin
                  ctrl.reg_we = 1'b1;
                  ctrl.dst_rd = 1'b1;
                  ctrl.alu_op = mips_core_pkg::ALU_OR;
               end
               mips_isa_pkg::F_XOR:
               begin
                  ctrl.reg_we = 1'b1;
                  ctrl.dst_rd = 1'b1;
                  ctrl.alu_op = mips_core_pkg::ALU_XOR;
               end
               mips_isa_pkg::F_NOR:
               begin
                  ctrl.reg_we = 1'b1;
                  ctrl.dst_rd = 1'b1;
                  ctrl.alu_op = mips_core_pkg::ALU_NOR;
               end
               mips_isa_pkg::F_SLT:
               begin
                  ctrl.reg_we = 1'b1;
                  ctrl.dst_rd = 1'b1;
                  ctrl.alu_op = mips_core_pkg::ALU_SLT;
               end
               // reserved funct
               default: ctrl.halt_req = 1'b1;
            endcase
         end
         mips_isa_pkg::OP_J: ctrl.pc_sel = mips_core_pkg::PC_JUMP;
         mips_isa_pkg::OP_JAL:
         begin
            ctrl.pc_sel = mips_core_pkg::PC_JUMP;
            ctrl.reg_we = 1'b1;
            ctrl.link   = 1'b1;
            ctrl.wb_sel = mips_core_pkg::WB_LINK;
         end
         mips_isa_pkg::OP_BEQ: ctrl.pc_sel = mips_core_pkg::PC_BRANCH;
         mips_isa_pkg::OP_BNE:
         begin
            ctrl.pc_sel    = mips_core_pkg::PC_BRANCH;
            ctrl.branch_ne = 1'b1;
         end
         // addiu, slti sign-extend; logical immediates zero-extend
         mips_isa_pkg::OP_ADDIU:
         begin
            ctrl.reg_we     = 1'b1;
            ctrl.imm_src    = 1'b1;
            ctrl.imm_signed = 1'b1;
         end
         mips_isa_pkg::OP_SLTI:
         begin
            ctrl.reg_we     = 1'b1;
            ctrl.imm_src    = 1'b1;
            ctrl.imm_signed = 1'b1;
            ctrl.alu_op     = mips_core_pkg::ALU_SLT;
         end
         mips_isa_pkg::OP_ANDI:
         begin
            ctrl.reg_we  = 1'b1;
            ctrl.imm_src = 1'b1;
            ctrl.alu_op  = mips_core_pkg::ALU_AND;
         end
         mips_isa_pkg::OP_ORI:
         begin
            ctrl.reg_we  = 1'b1;
            ctrl.imm_src = 1'b1;
            ctrl.alu_op  = mips_core_pkg::ALU_OR;
         end
         mips_isa_pkg::OP_XORI:
         begin
            ctrl.reg_we  = 1'b1;
            ctrl.imm_src = 1'b1;
            ctrl.alu_op  = mips_core_pkg::ALU_XOR;
         end
         mips_isa_pkg::OP_LUI:
         begin
            ctrl.reg_we  = 1'b1;
            ctrl.imm_src = 1'b1;
            ctrl.alu_op  = mips_core_pkg::ALU_LUI;
         end
         // address is rs + signed offset for both memory ops
         mips_isa_pkg::OP_LW:
         begin
            ctrl.reg_we     = 1'b1;
            ctrl.imm_src    = 1'b1;
            ctrl.imm_signed = 1'b1;
            ctrl.wb_sel     = mips_core_pkg::WB_LOAD;
         end
         mips_isa_pkg::OP_SW:
         begin
            ctrl.mem_we     = 1'b1;
            ctrl.imm_src    = 1'b1;
            ctrl.imm_signed = 1'b1;
         end
         // reserved opcode
         default: ctrl.halt_req = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/mips_fetch.sv
// TEXT_START must be word aligned; pc freezes on the halting instruction until reset
`default_nettype none

module mips_fetch #(
   parameter mips_isa_pkg::word_t TEXT_START = 32'h0040_0000
) (
   input  wire logic                clk,
   input  wire logic                rst_b,
   input  mips_isa_pkg::instr_t     inst,
   input  mips_core_pkg::ctrl_t     ctrl,
   input  wire logic                branch_taken,
   input  mips_isa_pkg::word_t      rs_data,
   output mips_isa_pkg::word_t      pc,
   output logic [29:0]              inst_addr,
   output logic                     halted
);

   mips_isa_pkg::word_t pc_plus4;
   mips_isa_pkg::word_t br_target;
   mips_isa_pkg::word_t j_target;
   mips_isa_pkg::word_t next_pc;
   logic [15:0]         imm;

   assign imm      = {inst.rd, inst.shamt, inst.funct};
   assign pc_plus4 = pc + 32'd4;
   // offset counts words from the following instruction
   assign br_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
   // region bits from the current pc, 26-bit field as word index
   assign j_target = {pc[31:28], inst.rs, inst.rt, imm, 2'b00};

   always_comb
   begin
      case (ctrl.pc_sel)
         mips_core_pkg::PC_BRANCH: next_pc = branch_taken ? br_target : pc_plus4;
         mips_core_pkg::PC_REG:    next_pc = rs_data;
         mips_core_pkg::PC_JUMP:   next_pc = j_target;
         default:                  next_pc = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc     <= TEXT_START;
         halted <= 1'b0;
      end
      else
      begin
         // sticky until reset
         if (ctrl.halt_req)
            halted <= 1'b1;
         // hold on the halting instruction
         if (!ctrl.halt_req && !halted)
            pc <= next_pc;
      end
   end

   assign inst_addr = pc[31:2];

endmodule

`default_nettype wire

//--- verilog/mips_isa_pkg.sv
// architectural encodings only; covers the kept MIPS-I subset, all other opcodes count as reserved
`default_nettype none

package mips_isa_pkg;

   // one machine word, also the width of every GPR
   typedef logic [31:0] word_t;

   // GPR number
   typedef logic [4:0] reg_idx_t;

   // link register written by jal
   localparam reg_idx_t reg_ra = 5'd31;

   // field overlay of one instruction word
   // the 16-bit immediate is {rd, shamt, funct}
   // the 26-bit jump target is everything below op
   typedef struct packed {
      logic [5:0] op;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } instr_t;

   // primary opcodes that the core executes
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_JAL     = 6'h03,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } op_e;

   // funct codes under OP_SPECIAL
   typedef enum logic [5:0] {
      F_SLL     = 6'h00,
      F_SRL     = 6'h02,
      F_SRA     = 6'h03,
      F_JR      = 6'h08,
      F_SYSCALL = 6'h0c,
      F_ADDU    = 6'h21,
      F_SUBU    = 6'h23,
      F_AND     = 6'h24,
      F_OR      = 6'h25,
      F_XOR     = 6'h26,
      F_NOR     = 6'h27,
      F_SLT     = 6'h2a
   } funct_e;

endpackage

`default_nettype wire

//--- verilog/mips_regfile.sv
// reads are combinational, the write lands at the edge; $zero is not stored
`default_nettype none

module mips_regfile (
   input  wire logic               clk,
   input  wire logic               rst_b,
   input  mips_isa_pkg::reg_idx_t  rs,
   input  mips_isa_pkg::reg_idx_t  rt,
   input  mips_isa_pkg::reg_idx_t  wr_idx,
   input  mips_isa_pkg::word_t     wr_data,
   input  wire logic               we,
   output mips_isa_pkg::word_t     rs_data,
   output mips_isa_pkg::word_t     rt_data
);

   // registers 1..31 only
   mips_isa_pkg::word_t regs [31:1];

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end
      // writes to $zero are dropped
      else if (we && (wr_idx != 5'd0))
         regs[wr_idx] <= wr_data;
   end

   // no bypass needed, single-cycle core reads before the edge
   assign rs_data = (rs == 5'd0) ? '0 : regs[rs];
   assign rt_data = (rt == 5'd0) ? '0 : regs[rt];

endmodule

`default_nettype wire
